// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mem_sys_tb
FILELIST  = sim.f
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== logic/bank_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_dispatch #(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_LINES = 256,
  parameter int REQ_DEPTH  = 4
) (
  input  wire                           clk,
  input  wire                           rst,

  input  wire                           dma_wr_valid,
  input  wire mem_sys_pkg::addr_t       dma_wr_addr,
  input  wire mem_sys_pkg::strb_t       dma_wr_strb,
  input  wire mem_sys_pkg::data_t       dma_wr_data,
  output logic                          dma_wr_ready,

  input  wire                           dma_rd_valid,
  input  wire mem_sys_pkg::addr_t       dma_rd_addr,
  output logic                          dma_rd_ready,

  input  wire                           core_en,
  input  wire                           core_we,
  input  wire mem_sys_pkg::word_strb_t  core_strb,
  input  wire mem_sys_pkg::addr_t       core_addr,
  input  wire mem_sys_pkg::word_t       core_wr_data,

  input  wire                           rd_credit,

  bank_if.dispatch                      banks [NUM_BANKS]
);

  import mem_sys_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int ROW_WIDTH = $clog2(BANK_LINES);
  localparam int ROW_LSB   = LINE_OFFSET_BITS + BANK_BITS;

  dma_wr_req_t wr_din;
  dma_wr_req_t wr_head;
  addr_t       rd_head;
  logic        wr_valid;
  logic        rd_valid;
  logic        wr_pop;
  logic        rd_pop;

  //////////////////////////////////////////////////
  // DMA request queues
  //////////////////////////////////////////////////

  assign wr_din = '{addr: dma_wr_addr, strb: dma_wr_strb, data: dma_wr_data};

  req_fifo #(
    .DEPTH     (REQ_DEPTH),
    .payload_t (dma_wr_req_t)
  ) wr_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .push  (dma_wr_valid && dma_wr_ready),
    .din   (wr_din),
    .ready (dma_wr_ready),
    .pop   (wr_pop),
    .dout  (wr_head),
    .valid (wr_valid),
    .count ()
  );

  req_fifo #(
    .DEPTH     (REQ_DEPTH),
    .payload_t (addr_t)
  ) rd_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .push  (dma_rd_valid && dma_rd_ready),
    .din   (dma_rd_addr),
    .ready (dma_rd_ready),
    .pop   (rd_pop),
    .dout  (rd_head),
    .valid (rd_valid),
    .count ()
  );

  // A DMA request stays up until its queue has room for it
  a_wr_held: assert property (@(posedge clk) disable iff (rst)
    dma_wr_valid && !dma_wr_ready |=> dma_wr_valid)
    else $error("bank_dispatch: DMA write request dropped before transfer");

  a_rd_held: assert property (@(posedge clk) disable iff (rst)
    dma_rd_valid && !dma_rd_ready |=> dma_rd_valid)
    else $error("bank_dispatch: DMA read request dropped before transfer");

  //////////////////////////////////////////////////
  // Address decode and core lane placement
  //////////////////////////////////////////////////

  wire [BANK_BITS-1:0] core_bank = core_addr[LINE_OFFSET_BITS +: BANK_BITS];
  wire [BANK_BITS-1:0] wr_bank   = wr_head.addr[LINE_OFFSET_BITS +: BANK_BITS];
  wire [BANK_BITS-1:0] rd_bank   = rd_head[LINE_OFFSET_BITS +: BANK_BITS];

  wire [ROW_WIDTH-1:0] core_row = core_addr[ROW_LSB +: ROW_WIDTH];
  wire [ROW_WIDTH-1:0] wr_row   = wr_head.addr[ROW_LSB +: ROW_WIDTH];
  wire [ROW_WIDTH-1:0] rd_row   = rd_head[ROW_LSB +: ROW_WIDTH];

  // Address bit 2 picks the upper or lower word of the line
  wire   core_lane = core_addr[LINE_OFFSET_BITS-1];
  strb_t core_line_strb;
  data_t core_line_data;

  assign core_line_strb = !core_we  ? '0 :
                          core_lane ? {core_strb, {$bits(word_strb_t){1'b0}}} :
                                      {{$bits(word_strb_t){1'b0}}, core_strb};
  assign core_line_data = {core_wr_data, core_wr_data};

  //////////////////////////////////////////////////
  // Per-bank arbitration
  //////////////////////////////////////////////////

  wire [NUM_BANKS-1:0] core_hit;
  wire [NUM_BANKS-1:0] wr_gnt;
  wire [NUM_BANKS-1:0] rd_gnt;

  // A read waits until every queued write has drained, so it sees them all
  wire rd_allowed = rd_valid && !wr_valid && rd_credit;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_arb
    assign core_hit[b] = core_en && (core_bank == BANK_BITS'(b));
    assign wr_gnt[b]   = !core_hit[b] && wr_valid && (wr_bank == BANK_BITS'(b));
    assign rd_gnt[b]   = !core_hit[b] && rd_allowed && (rd_bank == BANK_BITS'(b));

    assign banks[b].en      = core_hit[b] || wr_gnt[b] || rd_gnt[b];
    assign banks[b].dma_rd  = rd_gnt[b];
    assign banks[b].wstrb   = core_hit[b] ? core_line_strb :
                              wr_gnt[b]   ? wr_head.strb : '0;
    assign banks[b].row     = core_hit[b] ? core_row :
                              wr_gnt[b]   ? wr_row : rd_row;
    assign banks[b].wr_data = core_hit[b] ? core_line_data : wr_head.data;
  end

  assign wr_pop = |wr_gnt;
  assign rd_pop = |rd_gnt;

endmodule

`default_nettype wire

// ==== logic/bank_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bank_if #(
  parameter int BANK_LINES = 256
);

  import mem_sys_pkg::*;

  localparam int ROW_WIDTH = $clog2(BANK_LINES);

  // Request side, one access per cycle
  logic                 en;
  strb_t                wstrb;
  logic [ROW_WIDTH-1:0] row;
  data_t                wr_data;
  logic                 dma_rd;

  // Return side, valid one cycle after en
  data_t                rd_data;
  logic                 dma_rd_done;

  modport dispatch (output en, wstrb, row, wr_data, dma_rd);

  modport bank (input en, wstrb, row, wr_data, dma_rd, output rd_data, dma_rd_done);

  modport collect (input en, dma_rd, rd_data, dma_rd_done);

endinterface

`default_nettype wire

// ==== logic/mem_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
  parameter int BANK_LINES = 256
) (
  input  wire      clk,
  input  wire      rst,

  bank_if.bank     port
);

  import mem_sys_pkg::*;

  //////////////////////////////////////////////////
  // Line storage
  //////////////////////////////////////////////////

  // One line per row, written byte by byte under the strobes
  data_t mem [BANK_LINES];

  always_ff @(posedge clk) begin
    if (port.en) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (port.wstrb[i])
          mem[port.row][8*i +: 8] <= port.wr_data[8*i +: 8];
      end
    end
  end

  //////////////////////////////////////////////////
  // Read return
  //////////////////////////////////////////////////

  // Read-first behaviour, a write returns the old line which nobody uses.
  // The data holds until the next access to this bank
  always_ff @(posedge clk) begin
    if (port.en)
      port.rd_data <= mem[port.row];
  end

  // Marks the cycle in which rd_data belongs to a DMA read
  always_ff @(posedge clk) begin
    if (rst)
      port.dma_rd_done <= 1'b0;
    else
      port.dma_rd_done <= port.en && port.dma_rd;
  end

endmodule

`default_nettype wire

// ==== logic/mem_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sys #(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_LINES = 256,
  parameter int REQ_DEPTH  = 4,
  parameter int RESP_DEPTH = 8
) (
  input  wire                           clk,
  input  wire                           rst,

  // DMA write requests
  input  wire                           dma_wr_valid,
  input  wire mem_sys_pkg::addr_t       dma_wr_addr,
  input  wire mem_sys_pkg::strb_t       dma_wr_strb,
  input  wire mem_sys_pkg::data_t       dma_wr_data,
  output logic                          dma_wr_ready,

  // DMA read requests
  input  wire                           dma_rd_valid,
  input  wire mem_sys_pkg::addr_t       dma_rd_addr,
  output logic                          dma_rd_ready,

  // DMA read responses, in request order
  output logic                          dma_resp_valid,
  output mem_sys_pkg::data_t            dma_resp_data,
  input  wire                           dma_resp_ready,

  // Core word port, never stalled
  input  wire                           core_en,
  input  wire                           core_we,
  input  wire mem_sys_pkg::word_strb_t  core_strb,
  input  wire mem_sys_pkg::addr_t       core_addr,
  input  wire mem_sys_pkg::word_t       core_wr_data,
  output mem_sys_pkg::word_t            core_rd_data,
  output logic                          core_rd_valid
);

  if (NUM_BANKS < 2 || (NUM_BANKS & (NUM_BANKS - 1)) != 0) begin : g_bad_banks
    $error("mem_sys: NUM_BANKS must be a power of two and at least 2");
  end

  logic rd_credit;

  bank_if #(.BANK_LINES(BANK_LINES)) bank_bus [NUM_BANKS] ();

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  bank_dispatch #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_LINES (BANK_LINES),
    .REQ_DEPTH  (REQ_DEPTH)
  ) dispatch_i (
    .clk          (clk),
    .rst          (rst),
    .dma_wr_valid (dma_wr_valid),
    .dma_wr_addr  (dma_wr_addr),
    .dma_wr_strb  (dma_wr_strb),
    .dma_wr_data  (dma_wr_data),
    .dma_wr_ready (dma_wr_ready),
    .dma_rd_valid (dma_rd_valid),
    .dma_rd_addr  (dma_rd_addr),
    .dma_rd_ready (dma_rd_ready),
    .core_en      (core_en),
    .core_we      (core_we),
    .core_strb    (core_strb),
    .core_addr    (core_addr),
    .core_wr_data (core_wr_data),
    .rd_credit    (rd_credit),
    .banks        (bank_bus)
  );

  //////////////////////////////////////////////////
  // Banks
  //////////////////////////////////////////////////

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    mem_bank #(
      .BANK_LINES (BANK_LINES)
    ) bank_i (
      .clk  (clk),
      .rst  (rst),
      .port (bank_bus[b])
    );
  end

  //////////////////////////////////////////////////
  // Return side
  //////////////////////////////////////////////////

  resp_collect #(
    .NUM_BANKS  (NUM_BANKS),
    .RESP_DEPTH (RESP_DEPTH)
  ) collect_i (
    .clk            (clk),
    .rst            (rst),
    .banks          (bank_bus),
    .core_en        (core_en),
    .core_we        (core_we),
    .core_addr      (core_addr),
    .core_rd_data   (core_rd_data),
    .core_rd_valid  (core_rd_valid),
    .dma_resp_valid (dma_resp_valid),
    .dma_resp_data  (dma_resp_data),
    .dma_resp_ready (dma_resp_ready),
    .rd_credit      (rd_credit)
  );

endmodule

`default_nettype wire

// ==== logic/mem_sys_pkg.sv ====
`default_nettype none

package mem_sys_pkg;

  //////////////////////////////////////////////////
  // Address geometry
  //////////////////////////////////////////////////

  // Byte address width seen by both the DMA and the core
  localparam int ADDR_WIDTH = 16;

  // One line is the unit of a bank access and of every DMA transfer
  localparam int LINE_BYTES = 8;
  localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);

  // Core words are a fixed 32 bits
  localparam int WORD_BYTES = 4;

  //////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////

  typedef logic [8*LINE_BYTES-1:0] data_t;
  typedef logic [LINE_BYTES-1:0] strb_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  typedef logic [8*WORD_BYTES-1:0] word_t;
  typedef logic [WORD_BYTES-1:0] word_strb_t;

  // A queued DMA write carries the full byte address, so the bank and
  // row are decoded again at the head of the write FIFO
  typedef struct packed {
    addr_t addr;
    strb_t strb;
    data_t data;
  } dma_wr_req_t;

endpackage

`default_nettype wire

// ==== logic/req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
  parameter int DEPTH = 4,
  parameter type payload_t = logic [7:0]
) (
  input  wire                               clk,
  input  wire                               rst,

  input  wire                               push,
  input  wire payload_t                     din,
  output logic                              ready,

  input  wire                               pop,
  output payload_t                          dout,
  output logic                              valid,

  output logic [$clog2(DEPTH+1)-1:0]        count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign ready = (count != CNT_W'(DEPTH));
  assign valid = (count != '0);

  assign do_push = push && ready;
  assign do_pop  = pop && valid;

  // Show-ahead output, the head entry is always on dout
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  // DEPTH is a power of two, so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  // The producer must honour ready, or hold a credit that covers the push
  a_no_push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> ready)
    else $error("req_fifo: push while full");

endmodule

`default_nettype wire

// ==== logic/resp_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_collect #(
  parameter int NUM_BANKS  = 2,
  parameter int RESP_DEPTH = 8
) (
  input  wire                      clk,
  input  wire                      rst,

  bank_if.collect                  banks [NUM_BANKS],

  input  wire                      core_en,
  input  wire                      core_we,
  input  wire mem_sys_pkg::addr_t  core_addr,
  output mem_sys_pkg::word_t       core_rd_data,
  output logic                     core_rd_valid,

  output logic                     dma_resp_valid,
  output mem_sys_pkg::data_t       dma_resp_data,
  input  wire                      dma_resp_ready,

  output logic                     rd_credit
);

  import mem_sys_pkg::*;

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int CNT_W     = $clog2(RESP_DEPTH + 1);

  data_t               bank_rd_data [NUM_BANKS];
  wire [NUM_BANKS-1:0] rd_done;
  wire [NUM_BANKS-1:0] rd_issue;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_tap
    assign bank_rd_data[b] = banks[b].rd_data;
    assign rd_done[b]      = banks[b].dma_rd_done;
    assign rd_issue[b]     = banks[b].en && banks[b].dma_rd;
  end

  //////////////////////////////////////////////////
  // Core read return
  //////////////////////////////////////////////////

  logic                 core_rd_r;
  logic [BANK_BITS-1:0] core_bank_r;
  logic                 core_lane_r;
  data_t                core_line;

  always_ff @(posedge clk) begin
    if (rst)
      core_rd_r <= 1'b0;
    else
      core_rd_r <= core_en && !core_we;
  end

  always_ff @(posedge clk) begin
    if (core_en) begin
      core_bank_r <= core_addr[LINE_OFFSET_BITS +: BANK_BITS];
      core_lane_r <= core_addr[LINE_OFFSET_BITS-1];
    end
  end

  assign core_line     = bank_rd_data[core_bank_r];
  assign core_rd_data  = core_lane_r ? core_line[63:32] : core_line[31:0];
  assign core_rd_valid = core_rd_r;

  //////////////////////////////////////////////////
  // DMA response queue and credits
  //////////////////////////////////////////////////

  data_t            resp_din;
  logic [CNT_W-1:0] resp_count;
  logic             rd_in_flight;

  always_comb begin
    resp_din = bank_rd_data[0];
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (rd_done[b])
        resp_din = bank_rd_data[b];
    end
  end

  req_fifo #(
    .DEPTH     (RESP_DEPTH),
    .payload_t (data_t)
  ) resp_fifo_i (
    .clk   (clk),
    .rst   (rst),
    .push  (|rd_done),
    .din   (resp_din),
    .ready (),
    .pop   (dma_resp_ready),
    .dout  (dma_resp_data),
    .valid (dma_resp_valid),
    .count (resp_count)
  );

  // A read granted last cycle has not reached the FIFO count yet
  always_ff @(posedge clk) begin
    if (rst)
      rd_in_flight <= 1'b0;
    else
      rd_in_flight <= |rd_issue;
  end

  assign rd_credit = ({1'b0, resp_count} + (CNT_W+1)'(rd_in_flight)) < (CNT_W+1)'(RESP_DEPTH);

  // Reads leave the dispatcher one at a time, so returns never collide
  a_one_done: assert property (@(posedge clk) disable iff (rst) $onehot0(rd_done))
    else $error("resp_collect: several banks returned DMA data at once");

endmodule

`default_nettype wire

// ==== sim.f ====
logic/mem_sys_pkg.sv
logic/req_fifo.sv
logic/bank_if.sv
logic/bank_dispatch.sv
logic/mem_bank.sv
logic/resp_collect.sv
logic/mem_sys.sv
verification/mem_sys_tb.sv

// ==== verification/mem_sys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_sys_tb;

  import mem_sys_pkg::*;

  localparam int NUM_BANKS  = 2;
  localparam int BANK_LINES = 256;
  localparam int REQ_DEPTH  = 4;
  localparam int RESP_DEPTH = 8;

  // The banks together hold 512 lines, so 12 address bits are backed by storage
  localparam int LINE_BITS = $clog2(NUM_BANKS * BANK_LINES);
  localparam int MEM_ABITS = LINE_BITS + LINE_OFFSET_BITS;

  localparam int HANDSHAKE_TIMEOUT = 1000;
  localparam int RESP_TIMEOUT      = 5000;

  logic       clk;
  logic       rst;
  logic       dma_wr_valid;
  addr_t      dma_wr_addr;
  strb_t      dma_wr_strb;
  data_t      dma_wr_data;
  logic       dma_wr_ready;
  logic       dma_rd_valid;
  addr_t      dma_rd_addr;
  logic       dma_rd_ready;
  logic       dma_resp_valid;
  data_t      dma_resp_data;
  logic       dma_resp_ready;
  logic       core_en;
  logic       core_we;
  word_strb_t core_strb;
  addr_t      core_addr;
  word_t      core_wr_data;
  word_t      core_rd_data;
  logic       core_rd_valid;

  logic [7:0]  model_mem [2**MEM_ABITS];
  data_t       exp_q [$];
  addr_t       addr_list [$];
  addr_t       read_list [$];
  logic [15:0] lfsr;
  int          error_count;
  int          check_count;
  int          test_start;
  bit          rd_ready_low_seen;

  mem_sys #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_LINES (BANK_LINES),
    .REQ_DEPTH  (REQ_DEPTH),
    .RESP_DEPTH (RESP_DEPTH)
  ) dut_i (
    .clk            (clk),
    .rst            (rst),
    .dma_wr_valid   (dma_wr_valid),
    .dma_wr_addr    (dma_wr_addr),
    .dma_wr_strb    (dma_wr_strb),
    .dma_wr_data    (dma_wr_data),
    .dma_wr_ready   (dma_wr_ready),
    .dma_rd_valid   (dma_rd_valid),
    .dma_rd_addr    (dma_rd_addr),
    .dma_rd_ready   (dma_rd_ready),
    .dma_resp_valid (dma_resp_valid),
    .dma_resp_data  (dma_resp_data),
    .dma_resp_ready (dma_resp_ready),
    .core_en        (core_en),
    .core_we        (core_we),
    .core_strb      (core_strb),
    .core_addr      (core_addr),
    .core_wr_data   (core_wr_data),
    .core_rd_data   (core_rd_data),
    .core_rd_valid  (core_rd_valid)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Random numbers, checks and run control
  //////////////////////////////////////////////////

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      value = {value[62:0], fb};
    end
    return value;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic finish_run();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    error_count++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic report_test(input string name);
    if (error_count == test_start)
      $display("[%0t ns] %s: ok", $time, name);
    else
      $display("[%0t ns] %s: %0d errors", $time, name, error_count - test_start);
    test_start = error_count;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Every bit of the byte address takes part in the preload pattern
  function automatic logic [7:0] fill_byte(input logic [MEM_ABITS-1:0] a);
    return 8'(a) ^ 8'(a >> 4) ^ 8'h5c;
  endfunction

  function automatic logic [MEM_ABITS-1:0] line_base(input addr_t addr);
    return addr[MEM_ABITS-1:0] & ~MEM_ABITS'(LINE_BYTES - 1);
  endfunction

  function automatic data_t model_line(input addr_t addr);
    data_t line;
    for (int i = 0; i < LINE_BYTES; i++)
      line[8*i +: 8] = model_mem[line_base(addr) + MEM_ABITS'(i)];
    return line;
  endfunction

  function automatic word_t model_word(input addr_t addr);
    word_t word;
    for (int j = 0; j < 4; j++)
      word[8*j +: 8] = model_mem[addr[MEM_ABITS-1:0] + MEM_ABITS'(j)];
    return word;
  endfunction

  function automatic addr_t random_line();
    addr_t a;
    a = '0;
    a[LINE_OFFSET_BITS +: LINE_BITS] = LINE_BITS'(rand_bits(LINE_BITS));
    return a;
  endfunction

  //////////////////////////////////////////////////
  // Port drivers that start and end on a falling edge
  //////////////////////////////////////////////////

  task automatic dma_write(input addr_t addr, input strb_t strb, input data_t data);
    int cycles;
    dma_wr_valid = 1'b1;
    dma_wr_addr  = addr;
    dma_wr_strb  = strb;
    dma_wr_data  = data;
    cycles = 0;
    while (!dma_wr_ready && cycles < HANDSHAKE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!dma_wr_ready) begin
      timeout_abort("dma_wr_ready");
    end else begin
      // Accepted at the coming rising edge
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (strb[i])
          model_mem[line_base(addr) + MEM_ABITS'(i)] = data[8*i +: 8];
      end
      @(negedge clk);
      dma_wr_valid = 1'b0;
    end
  endtask

  task automatic dma_read(input addr_t addr);
    int cycles;
    dma_rd_valid = 1'b1;
    dma_rd_addr  = addr;
    cycles = 0;
    while (!dma_rd_ready && cycles < HANDSHAKE_TIMEOUT) begin
      rd_ready_low_seen = 1'b1;
      @(negedge clk);
      cycles++;
    end
    if (!dma_rd_ready) begin
      timeout_abort("dma_rd_ready");
    end else begin
      exp_q.push_back(model_line(addr));
      @(negedge clk);
      dma_rd_valid = 1'b0;
    end
  endtask

  task automatic issue_reads();
    foreach (read_list[i])
      dma_read(read_list[i]);
  endtask

  // Pops responses in order while ready is held high or kept mostly low
  task automatic collect_responses(input int count, input bit throttle);
    int received;
    int cycles;
    received = 0;
    cycles = 0;
    while (received < count && cycles < RESP_TIMEOUT) begin
      if (throttle)
        dma_resp_ready = (rand_bits(3) == 64'd7);
      else
        dma_resp_ready = 1'b1;
      if (dma_resp_valid && dma_resp_ready) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("DMA response at %0t ns arrived with no read outstanding", $time);
        end else begin
          check_value("dma_resp_data", dma_resp_data, exp_q.pop_front());
        end
        received++;
      end
      @(negedge clk);
      cycles++;
    end
    dma_resp_ready = 1'b1;
    if (received < count)
      timeout_abort("DMA read responses");
  endtask

  task automatic read_lines_back(input bit throttle);
    fork
      issue_reads();
      collect_responses(read_list.size(), throttle);
    join
    check_value("outstanding DMA reads", 64'(exp_q.size()), 64'(0));
  endtask

  task automatic core_write(input addr_t addr, input word_strb_t strb, input word_t data);
    core_en      = 1'b1;
    core_we      = 1'b1;
    core_addr    = addr;
    core_strb    = strb;
    core_wr_data = data;
    for (int j = 0; j < 4; j++) begin
      if (strb[j])
        model_mem[addr[MEM_ABITS-1:0] + MEM_ABITS'(j)] = data[8*j +: 8];
    end
    @(negedge clk);
    core_en = 1'b0;
    core_we = 1'b0;
  endtask

  // Read data is due exactly one cycle after the request
  task automatic core_read_check(input addr_t addr);
    word_t expected;
    expected  = model_word(addr);
    core_en   = 1'b1;
    core_we   = 1'b0;
    core_addr = addr;
    core_strb = '0;
    @(negedge clk);
    core_en = 1'b0;
    check_value("core_rd_valid", 64'(core_rd_valid), 64'(1));
    check_value("core_rd_data", 64'(core_rd_data), 64'(expected));
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    addr_t a;
    data_t fill_line;
    clk            = 1'b0;
    rst            = 1'b1;
    dma_wr_valid   = 1'b0;
    dma_wr_addr    = '0;
    dma_wr_strb    = '0;
    dma_wr_data    = '0;
    dma_rd_valid   = 1'b0;
    dma_rd_addr    = '0;
    dma_resp_ready = 1'b1;
    core_en        = 1'b0;
    core_we        = 1'b0;
    core_strb      = '0;
    core_addr      = '0;
    core_wr_data   = '0;
    lfsr           = 16'd10226;
    error_count    = 0;
    check_count    = 0;
    test_start     = 0;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_value("dma_resp_valid", 64'(dma_resp_valid), 64'(0));
    check_value("core_rd_valid", 64'(core_rd_valid), 64'(0));
    check_value("dma_wr_ready", 64'(dma_wr_ready), 64'(1));
    check_value("dma_rd_ready", 64'(dma_rd_ready), 64'(1));
    report_test("reset state");

    // Every line gets known contents before anything reads it
    for (int n = 0; n < NUM_BANKS * BANK_LINES; n++) begin
      a = addr_t'(n << LINE_OFFSET_BITS);
      for (int i = 0; i < LINE_BYTES; i++)
        fill_line[8*i +: 8] = fill_byte(line_base(a) + MEM_ABITS'(i));
      dma_write(a, '1, fill_line);
    end

    addr_list.delete();
    for (int n = 0; n < 32; n++) begin
      a = random_line();
      addr_list.push_back(a);
      dma_write(a, LINE_BYTES'(rand_bits(LINE_BYTES)), rand_bits(64));
    end
    read_list = addr_list;
    read_lines_back(1'b0);
    report_test("DMA write and read-back");

    addr_list.delete();
    for (int n = 0; n < 32; n++) begin
      a = '0;
      a[2 +: LINE_BITS+1] = (LINE_BITS+1)'(rand_bits(LINE_BITS + 1));
      addr_list.push_back(a);
      core_write(a, 4'(rand_bits(4)), 32'(rand_bits(32)));
    end
    foreach (addr_list[i])
      core_read_check(addr_list[i]);
    @(negedge clk);
    check_value("core_rd_valid", 64'(core_rd_valid), 64'(0));
    report_test("core word access");

    addr_list.delete();
    for (int n = 0; n < 8; n++) begin
      a = random_line();
      addr_list.push_back(a);
      dma_write(a, LINE_BYTES'(rand_bits(LINE_BYTES)), rand_bits(64));
    end
    // One read drains the write queue before the core touches those lines
    read_list.delete();
    read_list.push_back(addr_list[0]);
    read_lines_back(1'b0);
    foreach (addr_list[i]) begin
      a = addr_list[i];
      a[LINE_OFFSET_BITS-1] = 1'(rand_bits(1));
      core_write(a, 4'(rand_bits(4)), 32'(rand_bits(32)));
    end
    read_list = addr_list;
    read_lines_back(1'b0);
    report_test("cross-port visibility");

    read_list.delete();
    for (int n = 0; n < 24; n++)
      read_list.push_back(random_line());
    rd_ready_low_seen = 1'b0;
    read_lines_back(1'b1);
    if (!rd_ready_low_seen) begin
      error_count++;
      $display("dma_rd_ready never dropped while the response path was blocked");
    end
    report_test("back-pressure");

    finish_run();
  end

endmodule

`default_nettype wire
